// ==== reg_table.f ====
+incdir+include
src/reg_table_pkg.sv
src/operand_lookup.sv
src/entry_alloc.sv
src/reg_table_ctrl.sv
src/entry_store.sv
src/reg_table_top.sv
sim/reg_table_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register scoreboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f reg_table.f --top-module reg_table_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vreg_table_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# Verdict comes from the log
if grep -q "Regression failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== sim/reg_table_tb.sv ====
// ##############################
// // Register scoreboard testbench
// // Row table of inserts and writebacks against expected operand state
// ##############################

`default_nettype none

module reg_table_tb;

    // Cycles allowed for the table to read empty after reset
    localparam int RESET_TIMEOUT = 16;
    localparam reg_table_pkg::wb_t NO_WB = '0;

    logic                         clk_i;
    logic                         rst_n_i;
    reg_table_pkg::insert_req_t   insert_req_i;
    reg_table_pkg::wb_t           wb_i;
    reg_table_pkg::operand_res_t  operands_o;
    logic                         all_dst_written_o;

    int          error_count;
    logic [31:0] lfsr_state;

    // ##########################
    // Row table
    // ##########################

    string                      row_name  [$];
    reg_table_pkg::insert_req_t row_req   [$];
    reg_table_pkg::wb_t         row_wb    [$];
    reg_table_pkg::op_mask_t    row_ready [$];
    reg_table_pkg::tag_t        row_tag0  [$];
    reg_table_pkg::tag_t        row_tag1  [$];
    logic                       row_all   [$];

    reg_table_top reg_table_top_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .insert_req_i      (insert_req_i),
        .wb_i              (wb_i),
        .operands_o        (operands_o),
        .all_dst_written_o (all_dst_written_o)
    );

    // 40 unit period
    always #20 clk_i = ~clk_i;

    // Galois LFSR, taps for x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken, LSB first
    task automatic rand_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < n; b++) begin
            bits[b]    = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic reg_table_pkg::insert_req_t make_req(
        input logic                    ins,
        input reg_table_pkg::subwarp_id_t sw,
        input reg_table_pkg::reg_idx_t dst,
        input reg_table_pkg::tag_t     tag,
        input reg_table_pkg::reg_idx_t op0,
        input reg_table_pkg::reg_idx_t op1
    );
        reg_table_pkg::insert_req_t r;
        r            = '0;
        r.insert     = ins;
        r.subwarp_id = sw;
        r.dst        = dst;
        r.tag        = tag;
        r.op_reg[0]  = op0;
        r.op_reg[1]  = op1;
        return r;
    endfunction

    // Lookup only, no insert strobe
    function automatic reg_table_pkg::insert_req_t look(
        input reg_table_pkg::subwarp_id_t sw,
        input reg_table_pkg::reg_idx_t op0,
        input reg_table_pkg::reg_idx_t op1
    );
        return make_req(1'b0, sw, 4'd0, 2'd0, op0, op1);
    endfunction

    function automatic reg_table_pkg::wb_t make_wb(
        input logic v0,
        input reg_table_pkg::tag_t t0,
        input logic v1,
        input reg_table_pkg::tag_t t1
    );
        reg_table_pkg::wb_t w;
        w          = '0;
        w.valid[0] = v0;
        w.tag[0]   = t0;
        w.valid[1] = v1;
        w.tag[1]   = t1;
        return w;
    endfunction

    task automatic add_row(
        input string                      name,
        input reg_table_pkg::insert_req_t req,
        input reg_table_pkg::wb_t         wb,
        input reg_table_pkg::op_mask_t    ready,
        input reg_table_pkg::tag_t        t0,
        input reg_table_pkg::tag_t        t1,
        input logic                       all
    );
        row_name.push_back(name);
        row_req.push_back(req);
        row_wb.push_back(wb);
        row_ready.push_back(ready);
        row_tag0.push_back(t0);
        row_tag1.push_back(t1);
        row_all.push_back(all);
    endtask

    // Ready mask bit 0 is operand 0, expectations reflect the table before the row's edge
    task automatic build_table();
        logic [31:0] bits;
        add_row("idle_after_reset", look(1'b0, 4'd3, 4'd5), NO_WB, 2'b11, 2'd0, 2'd0, 1'b1);
        // Empty table, random registers all ready
        for (int k = 0; k < 3; k++) begin
            rand_bits(9, bits);
            add_row("lfsr_empty", look(bits[8], bits[3:0], bits[7:4]), NO_WB,
                    2'b11, 2'd0, 2'd0, 1'b1);
        end
        // Insert then look up in both subwarps
        add_row("insert_r3_t1", make_req(1'b1, 1'b0, 4'd3, 2'd1, 4'd3, 4'd4), NO_WB,
                2'b11, 2'd0, 2'd0, 1'b1);
        add_row("lookup_r3_sw0", look(1'b0, 4'd3, 4'd4), NO_WB, 2'b10, 2'd1, 2'd0, 1'b0);
        add_row("lookup_r3_sw1", look(1'b1, 4'd3, 4'd3), NO_WB, 2'b11, 2'd0, 2'd0, 1'b0);
        // Writeback bypass, then entry gone
        add_row("wb_bypass_t1", look(1'b0, 4'd3, 4'd3), make_wb(1'b1, 2'd1, 1'b0, 2'd0),
                2'b11, 2'd1, 2'd1, 1'b0);
        add_row("after_wb_t1", look(1'b0, 4'd3, 4'd3), NO_WB, 2'b11, 2'd0, 2'd0, 1'b1);
        // Reuse replaces the producer tag
        add_row("insert_r7_t2", make_req(1'b1, 1'b1, 4'd7, 2'd2, 4'd7, 4'd7), NO_WB,
                2'b11, 2'd0, 2'd0, 1'b1);
        add_row("reinsert_r7_t3", make_req(1'b1, 1'b1, 4'd7, 2'd3, 4'd7, 4'd2), NO_WB,
                2'b10, 2'd2, 2'd0, 1'b0);
        add_row("wb_old_t2", look(1'b1, 4'd7, 4'd7), make_wb(1'b1, 2'd2, 1'b0, 2'd0),
                2'b00, 2'd3, 2'd3, 1'b0);
        add_row("still_pending_t3", look(1'b1, 4'd7, 4'd0), NO_WB, 2'b10, 2'd3, 2'd0, 1'b0);
        add_row("wb_new_t3", look(1'b1, 4'd7, 4'd7), make_wb(1'b0, 2'd0, 1'b1, 2'd3),
                2'b11, 2'd3, 2'd3, 1'b0);
        add_row("r7_freed", look(1'b1, 4'd7, 4'd7), NO_WB, 2'b11, 2'd0, 2'd0, 1'b1);
        // Fill all four entries
        add_row("fill_e0", make_req(1'b1, 1'b0, 4'd1, 2'd0, 4'd1, 4'd2), NO_WB,
                2'b11, 2'd0, 2'd0, 1'b1);
        add_row("fill_e1", make_req(1'b1, 1'b0, 4'd2, 2'd1, 4'd1, 4'd2), NO_WB,
                2'b10, 2'd0, 2'd0, 1'b0);
        add_row("fill_e2", make_req(1'b1, 1'b1, 4'd1, 2'd2, 4'd1, 4'd2), NO_WB,
                2'b11, 2'd0, 2'd0, 1'b0);
        add_row("fill_e3", make_req(1'b1, 1'b1, 4'd5, 2'd3, 4'd1, 4'd5), NO_WB,
                2'b10, 2'd2, 2'd0, 1'b0);
        add_row("full_lookup", look(1'b1, 4'd5, 4'd1), NO_WB, 2'b00, 2'd3, 2'd2, 1'b0);
        // Two writebacks per cycle drain the table
        add_row("dual_wb_t0_t3", look(1'b0, 4'd1, 4'd2), make_wb(1'b1, 2'd0, 1'b1, 2'd3),
                2'b01, 2'd0, 2'd1, 1'b0);
        add_row("after_dual_wb", look(1'b1, 4'd1, 4'd5), NO_WB, 2'b10, 2'd2, 2'd0, 1'b0);
        add_row("dual_wb_t2_t1", look(1'b0, 4'd2, 4'd1), make_wb(1'b1, 2'd2, 1'b1, 2'd1),
                2'b11, 2'd1, 2'd0, 1'b0);
        add_row("all_written", look(1'b1, 4'd2, 4'd1), NO_WB, 2'b11, 2'd0, 2'd0, 1'b1);
    endtask

    // ##########################
    // Checks
    // ##########################

    task automatic stop_run(input string reason);
        error_count++;
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_op_mask(input string name, input reg_table_pkg::op_mask_t exp,
                                 input reg_table_pkg::op_mask_t act);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED %s ready: expected %b, actual %b",
                               name, exp, act));
        end
    endtask

    task automatic check_tag(input string name, input int op, input reg_table_pkg::tag_t exp,
                             input reg_table_pkg::tag_t act);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED %s tag op%0d: expected %0d, actual %0d",
                               name, op, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED %s all written: expected %b, actual %b",
                               name, exp, act));
        end
    endtask

    // Table must read empty shortly after reset release
    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while (all_dst_written_o !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (all_dst_written_o !== 1'b1) begin
            stop_run("Timed out waiting for an empty table after reset");
        end
    endtask

    // ##########################
    // Main sequence
    // ##########################

    initial begin
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        insert_req_i = '0;
        wb_i         = '0;
        error_count  = 0;
        lfsr_state   = 32'h490e;
        build_table();

        repeat (8) @(posedge clk_i);
        #5;
        rst_n_i = 1'b1;
        wait_reset_done();

        for (int i = 0; i < row_name.size(); i++) begin
            @(posedge clk_i);
            #5;
            insert_req_i = row_req[i];
            wb_i         = row_wb[i];
            // Sample just ahead of the next edge
            #34;
            check_op_mask(row_name[i], row_ready[i], operands_o.ready);
            check_tag(row_name[i], 0, row_tag0[i], operands_o.tag[0]);
            check_tag(row_name[i], 1, row_tag1[i], operands_o.tag[1]);
            check_bit(row_name[i], row_all[i], all_dst_written_o);
        end

        @(posedge clk_i);
        #5;
        insert_req_i = '0;
        wb_i         = '0;

        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : reg_table_tb

`default_nettype wire

// ==== src/reg_table_top.sv ====
// ##############################
// // Register scoreboard top
// // Store, allocator, control and operand lookups
// ##############################

`default_nettype none

`include "reg_table_defines.svh"

module reg_table_top (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    input  wire reg_table_pkg::insert_req_t    insert_req_i,
    input  wire reg_table_pkg::wb_t            wb_i,
    output reg_table_pkg::operand_res_t        operands_o,
    output logic                               all_dst_written_o
);

    // ##########################
    // Table state
    // ##########################

    reg_table_pkg::entry_t [`RT_NUM_TAGS-1:0] entries;
    reg_table_pkg::entry_mask_t               valid;

    // Allocator to control
    logic                      hit;
    reg_table_pkg::entry_idx_t hit_idx;
    logic                      free;
    reg_table_pkg::entry_idx_t free_idx;

    // Control to store
    reg_table_pkg::entry_mask_t clear;
    logic                       wr_en;
    reg_table_pkg::entry_idx_t  wr_idx;
    reg_table_pkg::entry_t      wr_entry;
    logic                       reuse;

    // Per operand lookup results
    logic                op_ready [`RT_OPERANDS];
    reg_table_pkg::tag_t op_tag   [`RT_OPERANDS];

    entry_store entry_store_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .clear_i    (clear),
        .wr_en_i    (wr_en),
        .wr_idx_i   (wr_idx),
        .wr_entry_i (wr_entry),
        .reuse_i    (reuse),
        .entries_o  (entries),
        .valid_o    (valid)
    );

    entry_alloc entry_alloc_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (insert_req_i),
        .entries_i  (entries),
        .valid_i    (valid),
        .clear_i    (clear),
        .hit_o      (hit),
        .hit_idx_o  (hit_idx),
        .free_o     (free),
        .free_idx_o (free_idx)
    );

    reg_table_ctrl reg_table_ctrl_i (
        .req_i      (insert_req_i),
        .wb_i       (wb_i),
        .entries_i  (entries),
        .valid_i    (valid),
        .hit_i      (hit),
        .hit_idx_i  (hit_idx),
        .free_i     (free),
        .free_idx_i (free_idx),
        .clear_o    (clear),
        .wr_en_o    (wr_en),
        .wr_idx_o   (wr_idx),
        .wr_entry_o (wr_entry),
        .reuse_o    (reuse)
    );

    // ##########################
    // Operand lookups
    // ##########################

    for (genvar g = 0; g < `RT_OPERANDS; g++) begin : g_op
        operand_lookup operand_lookup_i (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .op_reg_i     (insert_req_i.op_reg[g]),
            .subwarp_id_i (insert_req_i.subwarp_id),
            .entries_i    (entries),
            .valid_i      (valid),
            .wb_i         (wb_i),
            .ready_o      (op_ready[g]),
            .tag_o        (op_tag[g])
        );
    end

    // Gather lookup results into the output struct
    always_comb begin
        operands_o = '0;
        for (int o = 0; o < `RT_OPERANDS; o++) begin
            operands_o.ready[o] = op_ready[o];
            operands_o.tag[o]   = op_tag[o];
        end
    end

    // Nothing pending when no slot is valid
    assign all_dst_written_o = ~|valid;

endmodule : reg_table_top

`default_nettype wire

// ==== src/entry_store.sv ====
// ##############################
// // Entry store
// // Table registers and valid bits
// ##############################

`default_nettype none

`include "reg_table_defines.svh"

module entry_store (
    input  wire logic                                      clk_i,
    input  wire logic                                      rst_n_i,
    input  wire reg_table_pkg::entry_mask_t                clear_i,
    input  wire logic                                      wr_en_i,
    input  wire reg_table_pkg::entry_idx_t                 wr_idx_i,
    input  wire reg_table_pkg::entry_t                     wr_entry_i,
    input  wire logic                                      reuse_i,
    output reg_table_pkg::entry_t [`RT_NUM_TAGS-1:0]       entries_o,
    output reg_table_pkg::entry_mask_t                     valid_o
);

    reg_table_pkg::entry_mask_t valid_d;

    // Clear first, then the write sets its slot again
    always_comb begin
        valid_d = valid_o & ~clear_i;
        if (wr_en_i) begin
            valid_d[wr_idx_i] = 1'b1;
        end
    end

    // Valid bits are control state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= '0;
        end else begin
            valid_o <= valid_d;
        end
    end

    // Payload, only the producer changes on reuse
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            entries_o[wr_idx_i].producer <= wr_entry_i.producer;
            if (!reuse_i) begin
                entries_o[wr_idx_i].subwarp_id <= wr_entry_i.subwarp_id;
                entries_o[wr_idx_i].dst        <= wr_entry_i.dst;
            end
        end
    end

    // Allocator hit must keep one slot per destination and subwarp
    for (genvar i = 0; i < `RT_NUM_TAGS; i++) begin : g_uniq_i
        for (genvar j = i + 1; j < `RT_NUM_TAGS; j++) begin : g_uniq_j
            assert property (@(posedge clk_i) disable iff (!rst_n_i)
                (valid_o[i] && valid_o[j]) |->
                    (entries_o[i].dst != entries_o[j].dst
                     || entries_o[i].subwarp_id != entries_o[j].subwarp_id))
                else $error("Entries %0d and %0d hold the same destination", i, j);
        end
    end

endmodule : entry_store

`default_nettype wire

// ==== src/reg_table_ctrl.sv ====
// ##############################
// // Table control
// // Per-cycle clear mask and entry write
// ##############################

`default_nettype none

`include "reg_table_defines.svh"

module reg_table_ctrl (
    input  wire reg_table_pkg::insert_req_t                req_i,
    input  wire reg_table_pkg::wb_t                        wb_i,
    input  wire reg_table_pkg::entry_t [`RT_NUM_TAGS-1:0]  entries_i,
    input  wire reg_table_pkg::entry_mask_t                valid_i,
    input  wire logic                                      hit_i,
    input  wire reg_table_pkg::entry_idx_t                 hit_idx_i,
    input  wire logic                                      free_i,
    input  wire reg_table_pkg::entry_idx_t                 free_idx_i,
    output reg_table_pkg::entry_mask_t                     clear_o,
    output logic                                           wr_en_o,
    output reg_table_pkg::entry_idx_t                      wr_idx_o,
    output reg_table_pkg::entry_t                          wr_entry_o,
    output logic                                           reuse_o
);

    // ##########################
    // Writeback clear
    // ##########################

    // Drop every valid slot whose producer retires on any port
    always_comb begin
        clear_o = '0;
        for (int e = 0; e < `RT_NUM_TAGS; e++) begin
            for (int w = 0; w < `RT_WB_PORTS; w++) begin
                if (valid_i[e] && wb_i.valid[w]
                        && entries_i[e].producer == wb_i.tag[w]) begin
                    clear_o[e] = 1'b1;
                end
            end
        end
    end

    // ##########################
    // Insert write
    // ##########################

    // Pending destination gets its producer replaced
    assign reuse_o = req_i.insert && hit_i;

    // Write happens on reuse or when a free slot exists
    assign wr_en_o = req_i.insert && (hit_i || free_i);

    // Hit slot takes priority over the free slot
    assign wr_idx_o = hit_i ? hit_idx_i : free_idx_i;

    // New entry contents
    // store keeps dst and subwarp on reuse, they match anyway
    always_comb begin
        wr_entry_o            = '0;
        wr_entry_o.subwarp_id = req_i.subwarp_id;
        wr_entry_o.dst        = req_i.dst;
        wr_entry_o.producer   = req_i.tag;
    end

endmodule : reg_table_ctrl

`default_nettype wire

// ==== src/entry_alloc.sv ====
// ##############################
// // Entry allocator
// // Hit on pending destination, else lowest free slot
// ##############################

`default_nettype none

`include "reg_table_defines.svh"

module entry_alloc (
    input  wire logic                                      clk_i,
    input  wire logic                                      rst_n_i,
    input  wire reg_table_pkg::insert_req_t                req_i,
    input  wire reg_table_pkg::entry_t [`RT_NUM_TAGS-1:0]  entries_i,
    input  wire reg_table_pkg::entry_mask_t                valid_i,
    input  wire reg_table_pkg::entry_mask_t                clear_i,
    output logic                                           hit_o,
    output reg_table_pkg::entry_idx_t                      hit_idx_o,
    output logic                                           free_o,
    output reg_table_pkg::entry_idx_t                      free_idx_o
);

    // Slots still held once this cycle's writebacks retire
    reg_table_pkg::entry_mask_t held;

    assign held = valid_i & ~clear_i;

    // ##########################
    // Destination match
    // ##########################

    // Same dst and subwarp already pending, reuse that slot
    always_comb begin
        hit_o     = 1'b0;
        hit_idx_o = '0;
        for (int e = 0; e < `RT_NUM_TAGS; e++) begin
            if (!hit_o && valid_i[e] && entries_i[e].dst == req_i.dst
                    && entries_i[e].subwarp_id == req_i.subwarp_id) begin
                hit_o     = 1'b1;
                hit_idx_o = reg_table_pkg::entry_idx_t'(e);
            end
        end
    end

    // ##########################
    // Free slot search
    // ##########################

    // Lowest slot not held, a slot retiring now counts as free
    always_comb begin
        free_o     = 1'b0;
        free_idx_o = '0;
        for (int e = 0; e < `RT_NUM_TAGS; e++) begin
            if (!free_o && !held[e]) begin
                free_o     = 1'b1;
                free_idx_o = reg_table_pkg::entry_idx_t'(e);
            end
        end
    end

    // Decoder must not insert a new destination into a full table
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_i.insert && !hit_o) |-> free_o)
        else $error("Insert of dst %0d with no free entry", req_i.dst);

endmodule : entry_alloc

`default_nettype wire

// ==== src/operand_lookup.sv ====
// ##############################
// // Operand lookup
// // Pending producer of one operand, with writeback bypass
// ##############################

`default_nettype none

`include "reg_table_defines.svh"

module operand_lookup (
    input  wire logic                                      clk_i,
    input  wire logic                                      rst_n_i,
    input  wire reg_table_pkg::reg_idx_t                   op_reg_i,
    input  wire reg_table_pkg::subwarp_id_t                subwarp_id_i,
    input  wire reg_table_pkg::entry_t [`RT_NUM_TAGS-1:0]  entries_i,
    input  wire reg_table_pkg::entry_mask_t                valid_i,
    input  wire reg_table_pkg::wb_t                        wb_i,
    output logic                                           ready_o,
    output reg_table_pkg::tag_t                            tag_o
);

    // ##########################
    // Table scan
    // ##########################

    logic                match;
    reg_table_pkg::tag_t found_tag;
    logic                wb_hit;

    // First valid entry with same register and subwarp wins
    always_comb begin
        match     = 1'b0;
        found_tag = '0;
        for (int e = 0; e < `RT_NUM_TAGS; e++) begin
            if (!match && valid_i[e] && entries_i[e].dst == op_reg_i
                    && entries_i[e].subwarp_id == subwarp_id_i) begin
                match     = 1'b1;
                found_tag = entries_i[e].producer;
            end
        end
    end

    // ##########################
    // Writeback bypass
    // ##########################

    // Producer retiring this cycle makes the value available now
    always_comb begin
        wb_hit = 1'b0;
        for (int w = 0; w < `RT_WB_PORTS; w++) begin
            if (wb_i.valid[w] && wb_i.tag[w] == found_tag) begin
                wb_hit = 1'b1;
            end
        end
    end

    // Not ready only while a producer is pending and not retiring
    assign ready_o = !match || wb_hit;
    // Tag stays reported even when bypassed
    assign tag_o   = found_tag;

    // Any matching entry whose producer retires must leave the operand ready
    for (genvar e = 0; e < `RT_NUM_TAGS; e++) begin : g_bypass_chk
        for (genvar w = 0; w < `RT_WB_PORTS; w++) begin : g_port
            assert property (@(posedge clk_i) disable iff (!rst_n_i)
                (valid_i[e] && entries_i[e].dst == op_reg_i
                 && entries_i[e].subwarp_id == subwarp_id_i
                 && wb_i.valid[w] && wb_i.tag[w] == entries_i[e].producer) |-> ready_o)
                else $error("Entry %0d retired on port %0d but operand not ready", e, w);
        end
    end

endmodule : operand_lookup

`default_nettype wire

// ==== src/reg_table_pkg.sv ====
// ##############################
// // Register scoreboard types
// // Vector widths and packed structs shared by the table blocks
// ##############################

`default_nettype none

`include "reg_table_defines.svh"

package reg_table_pkg;

    // Scalar widths
    typedef logic [`RT_TAG_WIDTH-1:0]       tag_t;
    typedef logic [`RT_REG_IDX_WIDTH-1:0]   reg_idx_t;
    typedef logic [`RT_SUBWARP_WIDTH-1:0]   subwarp_id_t;
    typedef logic [$clog2(`RT_NUM_TAGS)-1:0] entry_idx_t;
    typedef logic [`RT_NUM_TAGS-1:0]        entry_mask_t;
    typedef logic [`RT_OPERANDS-1:0]        op_mask_t;

    // One table slot, destination owned by a producer tag
    typedef struct packed {
        subwarp_id_t subwarp_id;
        reg_idx_t    dst;
        tag_t        producer;
    } entry_t;

    // Decoder insert request
    typedef struct packed {
        logic                            insert;
        subwarp_id_t                     subwarp_id;
        reg_idx_t                        dst;
        tag_t                            tag;
        reg_idx_t [`RT_OPERANDS-1:0]     op_reg;
    } insert_req_t;

    // Execution unit writebacks, one valid and tag per port
    typedef struct packed {
        logic [`RT_WB_PORTS-1:0] valid;
        tag_t [`RT_WB_PORTS-1:0] tag;
    } wb_t;

    // Operand answer to the wait buffer
    typedef struct packed {
        op_mask_t                ready;
        tag_t [`RT_OPERANDS-1:0] tag;
    } operand_res_t;

endpackage : reg_table_pkg

`default_nettype wire

// ==== include/reg_table_defines.svh ====
// ##############################
// // Register scoreboard sizes
// // Table depth, tag and index widths, port counts
// ##############################

`ifndef REG_TABLE_DEFINES_SVH
`define REG_TABLE_DEFINES_SVH

// In-flight tags, one table entry per tag
`define RT_NUM_TAGS 4

// Producer tag width
`define RT_TAG_WIDTH 2

// Architectural register index width
`define RT_REG_IDX_WIDTH 4

// Subwarp id width, two subwarps
`define RT_SUBWARP_WIDTH 1

// Writeback ports checked each cycle
`define RT_WB_PORTS 2

// Source operands per instruction
`define RT_OPERANDS 2

`endif
